// ==== csr_subsys.f ====
+incdir+include
logic/csr_pkg.sv
logic/csr_bank_if.sv
logic/csr_bank.sv
logic/csr_exec.sv
logic/int_regfile.sv
logic/csr_subsys.sv
dv/csr_subsys_tb.sv

// ==== Makefile ====
# Verilator build and run for the CSR subsystem testbench

TOP := csr_subsys_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass line"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f csr_subsys.f --Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "^sim passed$$" $(LOG) || (echo "Test run did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// ==== dv/csr_subsys_tb.sv ====
/* CSR subsystem testbench */

`timescale 1ns/1ps
`default_nettype none

`include "csr_params.svh"

module csr_subsys_tb;

    localparam int TIMEOUT = 40;    // Falling edges per wait

    typedef struct packed {
        logic                do_srst;   // Pulse srst first
        logic                pre_en;    // ALU preload
        csr_pkg::reg_addr_t  pre_reg;
        csr_pkg::xlen_t      pre_val;
        csr_pkg::funct3_t    funct3;
        csr_pkg::csr_addr_t  csr;
        csr_pkg::reg_addr_t  src;       // rs1 index or zimm
        csr_pkg::reg_addr_t  rd;
        csr_pkg::xlen_t      exp_val;   // Old CSR value from the model
    } vec_t;

    logic                aclk;
    logic                aresetn;
    logic                srst;
    logic                valid;
    logic                ready;
    csr_pkg::inst_t      instbus;
    logic                alu_wr_en;
    csr_pkg::reg_addr_t  alu_wr_addr;
    csr_pkg::xlen_t      alu_wr_data;
    logic                rd_wr_en;
    csr_pkg::reg_addr_t  rd_wr_addr;
    csr_pkg::xlen_t      rd_wr_val;

    vec_t                vecs [$];
    string               names [$];
    csr_pkg::xlen_t      csr_m [csr_pkg::csr_addr_t];  // Writable CSRs only
    csr_pkg::xlen_t      reg_m [32];
    int                  seed = 95083;
    int                  errors = 0;
    int                  passed = 0;
    int                  failed = 0;
    logic                timed_out = 1'b0;

    csr_subsys u_csr_subsys (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .srst        (srst),
        .valid       (valid),
        .ready       (ready),
        .instbus     (instbus),
        .alu_wr_en   (alu_wr_en),
        .alu_wr_addr (alu_wr_addr),
        .alu_wr_data (alu_wr_data),
        .rd_wr_en    (rd_wr_en),
        .rd_wr_addr  (rd_wr_addr),
        .rd_wr_val   (rd_wr_val)
    );

    initial begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;    // 125 MHz
    end

    // ----------------------------------------
    // Reference model
    // ----------------------------------------

    // Bits 31, 22:11, 8:7, 5:3, 1:0
    function automatic csr_pkg::xlen_t mstatus_mask();
        csr_pkg::xlen_t m;
        m = '0;
        m[31] = 1'b1;
        m[22:11] = '1;
        m[8:7] = '1;
        m[5:3] = '1;
        m[1:0] = '1;
        return m;
    endfunction

    function automatic csr_pkg::xlen_t model_read(input csr_pkg::csr_addr_t addr);
        if (addr == `ADDR_MISA) begin
            return 32'h4000_0100;   // MXL=1, I base
        end
        if (addr == `ADDR_MHARTID || !csr_m.exists(addr)) begin
            return '0;
        end
        return csr_m[addr];
    endfunction

    task automatic model_write(input csr_pkg::csr_addr_t addr, input csr_pkg::xlen_t val);
        case (addr)
            `ADDR_MSTATUS: csr_m[addr] = val & mstatus_mask();
            `ADDR_MEPC:    csr_m[addr] = {val[31:2], 2'b00};
            `ADDR_MTVEC, `ADDR_MSCRATCH, `ADDR_MCAUSE, `ADDR_MTVAL: csr_m[addr] = val;
            default: ;      // Read-only or hole
        endcase
    endtask

    task automatic model_step(inout vec_t v);
        csr_pkg::xlen_t old;
        csr_pkg::xlen_t opnd;
        if (v.do_srst) begin
            csr_m.delete();
            for (int i = 0; i < 32; i++) begin
                reg_m[i] = '0;
            end
        end
        if (v.pre_en && v.pre_reg != '0) reg_m[v.pre_reg] = v.pre_val;
        old  = model_read(v.csr);
        opnd = v.funct3[2] ? {27'd0, v.src} : reg_m[v.src];    // Immediate forms
        case (v.funct3)
            `CSRRW, `CSRRWI: model_write(v.csr, opnd);
            `CSRRS, `CSRRSI: if (v.src != '0) model_write(v.csr, old | opnd);
            `CSRRC, `CSRRCI: if (v.src != '0) model_write(v.csr, old & ~opnd);
            default: ;
        endcase
        if (v.rd != '0) reg_m[v.rd] = old;
        v.exp_val = old;
    endtask

    // ----------------------------------------
    // Vector table
    // ----------------------------------------

    task automatic add_vec(input string name, input logic rst, input csr_pkg::reg_addr_t pre,
                           input csr_pkg::xlen_t pval, input csr_pkg::funct3_t f3,
                           input csr_pkg::csr_addr_t csr, input csr_pkg::reg_addr_t src,
                           input csr_pkg::reg_addr_t rd);
        vec_t v;
        v = '{rst, pre != '0, pre, pval, f3, csr, src, rd, 32'd0};
        model_step(v);      // Fills the expected column
        vecs.push_back(v);
        names.push_back(name);
    endtask

    task automatic build_table();
        // Swap and chained rd
        add_vec("mscratch swap", 1'b0, 5'd5, $random(seed), `CSRRW, `ADDR_MSCRATCH, 5'd5, 5'd6);
        add_vec("mscratch read", 1'b0, 5'd0, '0, `CSRRS, `ADDR_MSCRATCH, 5'd0, 5'd7);
        add_vec("mscratch chain", 1'b0, 5'd8, $random(seed), `CSRRW, `ADDR_MSCRATCH, 5'd8, 5'd9);
        add_vec("mscratch from rd", 1'b0, 5'd0, '0, `CSRRW, `ADDR_MSCRATCH, 5'd9, 5'd10);
        add_vec("mscratch reread", 1'b0, 5'd0, '0, `CSRRS, `ADDR_MSCRATCH, 5'd0, 5'd11);
        // Register set and clear on mtvec
        add_vec("mtvec write", 1'b0, 5'd12, $random(seed), `CSRRW, `ADDR_MTVEC, 5'd12, 5'd0);
        add_vec("mtvec set", 1'b0, 5'd13, $random(seed), `CSRRS, `ADDR_MTVEC, 5'd13, 5'd14);
        add_vec("mtvec clear", 1'b0, 5'd15, $random(seed), `CSRRC, `ADDR_MTVEC, 5'd15, 5'd16);
        add_vec("mtvec set x0", 1'b0, 5'd0, '0, `CSRRS, `ADDR_MTVEC, 5'd0, 5'd17);
        add_vec("mtvec clear x0", 1'b0, 5'd0, '0, `CSRRC, `ADDR_MTVEC, 5'd0, 5'd17);
        add_vec("mtvec read", 1'b0, 5'd0, '0, `CSRRS, `ADDR_MTVEC, 5'd0, 5'd18);
        // Immediate forms on mcause, bit 4 kept set for the srst check
        add_vec("mcause write imm", 1'b0, 5'd0, '0, `CSRRWI, `ADDR_MCAUSE,
                5'($random(seed)) | 5'h10, 5'd19);
        add_vec("mcause set imm", 1'b0, 5'd0, '0, `CSRRSI, `ADDR_MCAUSE, 5'($random(seed)), 5'd19);
        add_vec("mcause clear imm", 1'b0, 5'd0, '0, `CSRRCI, `ADDR_MCAUSE,
                5'($random(seed)) & 5'h0F, 5'd19);
        add_vec("mcause set zero", 1'b0, 5'd0, '0, `CSRRSI, `ADDR_MCAUSE, 5'd0, 5'd19);
        add_vec("mcause clear zero", 1'b0, 5'd0, '0, `CSRRCI, `ADDR_MCAUSE, 5'd0, 5'd19);
        add_vec("mcause read", 1'b0, 5'd0, '0, `CSRRS, `ADDR_MCAUSE, 5'd0, 5'd19);
        // Masked and aligned writes
        add_vec("mstatus ones", 1'b0, 5'd20, 32'hFFFF_FFFF, `CSRRW, `ADDR_MSTATUS, 5'd20, 5'd0);
        add_vec("mstatus read", 1'b0, 5'd0, '0, `CSRRS, `ADDR_MSTATUS, 5'd0, 5'd21);
        add_vec("mepc write", 1'b0, 5'd22, $random(seed) | 32'h3, `CSRRW, `ADDR_MEPC, 5'd22, 5'd0);
        add_vec("mepc read", 1'b0, 5'd0, '0, `CSRRS, `ADDR_MEPC, 5'd0, 5'd23);
        add_vec("mtval write", 1'b0, 5'd24, $random(seed), `CSRRW, `ADDR_MTVAL, 5'd24, 5'd0);
        add_vec("mtval read", 1'b0, 5'd0, '0, `CSRRS, `ADDR_MTVAL, 5'd0, 5'd23);
        // Read-only and unmapped
        add_vec("misa read", 1'b0, 5'd0, '0, `CSRRS, `ADDR_MISA, 5'd0, 5'd25);
        add_vec("misa write", 1'b0, 5'd0, '0, `CSRRW, `ADDR_MISA, 5'd20, 5'd25);
        add_vec("misa reread", 1'b0, 5'd0, '0, `CSRRS, `ADDR_MISA, 5'd0, 5'd25);
        add_vec("mhartid write", 1'b0, 5'd0, '0, `CSRRW, `ADDR_MHARTID, 5'd20, 5'd26);
        add_vec("mhartid read", 1'b0, 5'd0, '0, `CSRRS, `ADDR_MHARTID, 5'd0, 5'd26);
        add_vec("unmapped write", 1'b0, 5'd0, '0, `CSRRW, 12'h7C0, 5'd20, 5'd27);
        add_vec("unmapped read", 1'b0, 5'd0, '0, `CSRRS, 12'h7C0, 5'd0, 5'd27);
        // Synchronous reset clears the writable CSRs
        add_vec("srst mscratch", 1'b1, 5'd0, '0, `CSRRS, `ADDR_MSCRATCH, 5'd0, 5'd28);
        add_vec("srst mtvec", 1'b0, 5'd0, '0, `CSRRS, `ADDR_MTVEC, 5'd0, 5'd28);
        add_vec("srst mcause", 1'b0, 5'd0, '0, `CSRRS, `ADDR_MCAUSE, 5'd0, 5'd28);
        add_vec("srst mstatus", 1'b0, 5'd0, '0, `CSRRS, `ADDR_MSTATUS, 5'd0, 5'd28);
        add_vec("srst mepc", 1'b0, 5'd0, '0, `CSRRS, `ADDR_MEPC, 5'd0, 5'd28);
    endtask

    // ----------------------------------------
    // Apply one vector
    // ----------------------------------------

    // Entered and left on a falling edge
    task automatic run_vec(input int idx);
        vec_t v;
        int   waited;
        int   lat;
        int   rdy_low;
        int   err_start;
        v = vecs[idx];
        err_start = errors;
        if (v.do_srst) begin
            srst = 1'b1;
            @(negedge aclk);
            srst = 1'b0;
        end
        if (v.pre_en) begin
            alu_wr_en   = 1'b1;
            alu_wr_addr = v.pre_reg;
            alu_wr_data = v.pre_val;
            @(negedge aclk);
            alu_wr_en   = 1'b0;
        end
        waited = 0;
        while (!ready && waited < TIMEOUT) begin
            @(negedge aclk);
            waited++;
        end
        if (!ready) begin
            $display("test %0d %s: timed out, ready never went high", idx, names[idx]);
            timed_out = 1'b1;
            return;
        end
        valid   = 1'b1;
        instbus = {v.csr, v.src, v.funct3, v.rd, 7'b1110011};   // SYSTEM opcode
        @(negedge aclk);                                        // Accepted on the edge between
        valid   = 1'b0;
        lat     = 1;
        rdy_low = 0;
        while (!rd_wr_en && lat < TIMEOUT) begin
            rdy_low += ready ? 0 : 1;
            @(negedge aclk);
            lat++;
        end
        if (!rd_wr_en) begin
            $display("test %0d %s: timed out, no rd writeback pulse", idx, names[idx]);
            timed_out = 1'b1;
            return;
        end
        rdy_low += ready ? 0 : 1;
        assert (lat == 2) else begin
            $display("MISMATCH time %0t rd_wr_en latency got %0d expected 2", $time, lat);
            errors++;
        end
        assert (rd_wr_val == v.exp_val) else begin
            $display("MISMATCH time %0t rd_wr_val got %h expected %h",
                     $time, rd_wr_val, v.exp_val);
            errors++;
        end
        assert (rd_wr_addr == v.rd) else begin
            $display("MISMATCH time %0t rd_wr_addr got %0d expected %0d", $time, rd_wr_addr, v.rd);
            errors++;
        end
        @(negedge aclk);
        assert (!rd_wr_en) else begin
            $display("MISMATCH time %0t rd_wr_en got 1 expected 0", $time);
            errors++;
        end
        assert (ready) else begin
            $display("MISMATCH time %0t ready got 0 expected 1", $time);
            errors++;
        end
        // Low at the two edges after acceptance, next accept on the third
        assert (rdy_low == 2) else begin
            $display("MISMATCH time %0t ready low cycles got %0d expected 2", $time, rdy_low);
            errors++;
        end
        if (errors == err_start) begin
            $display("test %0d %s: ok", idx, names[idx]);
            passed++;
        end else begin
            $display("test %0d %s: FAIL", idx, names[idx]);
            failed++;
        end
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------

    initial begin
        aresetn     = 1'b0;
        srst        = 1'b0;
        valid       = 1'b0;
        instbus     = '0;
        alu_wr_en   = 1'b0;
        alu_wr_addr = '0;
        alu_wr_data = '0;
        for (int i = 0; i < 32; i++) begin
            reg_m[i] = '0;
        end
        build_table();
        repeat (2) @(posedge aclk);     // Two rising edges in reset
        @(negedge aclk);
        aresetn = 1'b1;
        for (int i = 0; i < vecs.size() && !timed_out; i++) begin
            run_vec(i);
        end
        failed += timed_out ? 1 : 0;
        $display("tests %0d of %0d run, %0d passed, %0d failed, %0d check errors",
                 passed + failed, vecs.size(), passed, failed, errors);
        if (errors == 0 && !timed_out && failed == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/csr_subsys.sv ====
/* CSR execution subsystem top */

`timescale 1ns/1ps
`default_nettype none

module csr_subsys (
    input  logic                aclk,
    input  logic                aresetn,
    input  logic                srst,
    // Issue stage
    input  logic                valid,
    output logic                ready,
    input  csr_pkg::inst_t      instbus,
    // ALU writeback from the core
    input  logic                alu_wr_en,
    input  csr_pkg::reg_addr_t  alu_wr_addr,
    input  csr_pkg::xlen_t      alu_wr_data,
    // CSR result to rd
    output logic                rd_wr_en,
    output csr_pkg::reg_addr_t  rd_wr_addr,
    output csr_pkg::xlen_t      rd_wr_val
);

    csr_pkg::reg_addr_t  rs1_addr;
    csr_pkg::xlen_t      rs1_val;

    csr_bank_if u_bank_if ();

    // ----------------------------------------
    // Execution unit
    // ----------------------------------------

    csr_exec u_csr_exec (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .srst       (srst),
        .valid      (valid),
        .ready      (ready),
        .instbus    (instbus),
        .rs1_addr   (rs1_addr),
        .rs1_val    (rs1_val),
        .rd_wr_en   (rd_wr_en),
        .rd_wr_addr (rd_wr_addr),
        .rd_wr_val  (rd_wr_val),
        .bank       (u_bank_if.exec)
    );

    // ----------------------------------------
    // Storage
    // ----------------------------------------

    csr_bank u_csr_bank (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .srst       (srst),
        .bank       (u_bank_if.bank)
    );

    int_regfile u_int_regfile (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .srst        (srst),
        .rs1_addr    (rs1_addr),
        .rs1_val     (rs1_val),
        .csr_wr_en   (rd_wr_en),
        .csr_wr_addr (rd_wr_addr),
        .csr_wr_data (rd_wr_val),
        .alu_wr_en   (alu_wr_en),
        .alu_wr_addr (alu_wr_addr),
        .alu_wr_data (alu_wr_data)
    );

endmodule

`default_nettype wire

// ==== logic/int_regfile.sv ====
/* Integer register file */

`timescale 1ns/1ps
`default_nettype none

module int_regfile (
    input  logic                aclk,
    input  logic                aresetn,
    input  logic                srst,
    // Read port, combinational
    input  csr_pkg::reg_addr_t  rs1_addr,
    output csr_pkg::xlen_t      rs1_val,
    // CSR writeback, wins on collision
    input  logic                csr_wr_en,
    input  csr_pkg::reg_addr_t  csr_wr_addr,
    input  csr_pkg::xlen_t      csr_wr_data,
    // ALU writeback
    input  logic                alu_wr_en,
    input  csr_pkg::reg_addr_t  alu_wr_addr,
    input  csr_pkg::xlen_t      alu_wr_data
);

    csr_pkg::xlen_t regs [32];  // Entry 0 never written

    // ----------------------------------------
    // Write ports
    // ----------------------------------------

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (srst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (alu_wr_en && alu_wr_addr != '0) begin
                regs[alu_wr_addr] <= alu_wr_data;
            end
            // Later assignment takes the collision
            if (csr_wr_en && csr_wr_addr != '0) begin
                regs[csr_wr_addr] <= csr_wr_data;
            end
        end
    end

    // ----------------------------------------
    // Read port
    // ----------------------------------------

    assign rs1_val = (rs1_addr == '0) ? '0 : regs[rs1_addr];   // x0 reads zero

endmodule

`default_nettype wire

// ==== logic/csr_exec.sv ====
/* Zicsr execution unit */

`timescale 1ns/1ps
`default_nettype none

`include "csr_params.svh"

module csr_exec (
    input  logic                aclk,
    input  logic                aresetn,
    input  logic                srst,
    // Issue side
    input  logic                valid,
    output logic                ready,
    input  csr_pkg::inst_t      instbus,
    // rs1 lookup
    output csr_pkg::reg_addr_t  rs1_addr,
    input  csr_pkg::xlen_t      rs1_val,
    // rd writeback
    output logic                rd_wr_en,
    output csr_pkg::reg_addr_t  rd_wr_addr,
    output csr_pkg::xlen_t      rd_wr_val,
    // CSR storage
    csr_bank_if.exec            bank
);

    // ----------------------------------------
    // Declarations
    // ----------------------------------------

    csr_pkg::exec_state_t state;

    // Live fields of instbus
    csr_pkg::funct3_t    funct3;
    csr_pkg::csr_addr_t  csr_addr;
    csr_pkg::reg_addr_t  rd;
    csr_pkg::reg_addr_t  zimm;

    logic                accept;

    // Captured at acceptance
    csr_pkg::funct3_t    funct3_r;
    csr_pkg::reg_addr_t  rs1_idx_r;
    csr_pkg::reg_addr_t  zimm_r;
    csr_pkg::xlen_t      rs1_val_r;

    csr_pkg::xlen_t      operand;
    csr_pkg::xlen_t      newval;
    logic                src_nz;    // rs1 index or zimm non zero
    logic                op_ok;     // Known funct3
    logic                wr_due;    // CSR write needed

    // ----------------------------------------
    // Instruction split
    // ----------------------------------------

    assign funct3   = instbus[`FUNCT3 +: `FUNCT3_W];
    assign rs1_addr = instbus[`RS1    +: `RS1_W];
    assign rd       = instbus[`RD     +: `RD_W];
    assign zimm     = instbus[`ZIMM   +: `ZIMM_W];
    assign csr_addr = instbus[`CSR    +: `CSR_W];

    assign accept = valid && ready && (state == csr_pkg::IDLE);

    // Bank read fires on the accept edge
    assign bank.rd_en   = accept;
    assign bank.rd_addr = csr_addr;

    // ----------------------------------------
    // New value
    // ----------------------------------------

    // funct3[2] picks the immediate forms
    assign operand = funct3_r[2] ? {{(`CSR_XLEN-`ZIMM_W){1'b0}}, zimm_r} : rs1_val_r;
    assign src_nz  = funct3_r[2] ? (zimm_r != '0) : (rs1_idx_r != '0);

    always_comb begin
        newval = bank.rd_data;
        op_ok  = 1'b1;
        wr_due = 1'b0;
        case (funct3_r)
            `CSRRW, `CSRRWI: begin
                newval = operand;                   // Plain swap
                wr_due = 1'b1;
            end
            `CSRRS, `CSRRSI: begin
                newval = bank.rd_data | operand;    // Set bits
                wr_due = src_nz;
            end
            `CSRRC, `CSRRCI: begin
                newval = bank.rd_data & ~operand;   // Clear bits
                wr_due = src_nz;
            end
            default: op_ok = 1'b0;                  // No rd, no CSR write
        endcase
    end

    // ----------------------------------------
    // Control FSM
    // ----------------------------------------

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state       <= csr_pkg::IDLE;
            ready       <= 1'b0;
            rd_wr_en    <= 1'b0;
            bank.wr_en  <= 1'b0;
        end else if (srst) begin
            state       <= csr_pkg::IDLE;
            ready       <= 1'b0;
            rd_wr_en    <= 1'b0;
            bank.wr_en  <= 1'b0;
        end else begin
            case (state)
                csr_pkg::IDLE: begin
                    rd_wr_en   <= 1'b0;
                    bank.wr_en <= 1'b0;
                    ready      <= 1'b1;
                    if (accept) begin
                        ready <= 1'b0;
                        state <= csr_pkg::COMPUTE;
                    end
                end
                csr_pkg::COMPUTE: begin
                    rd_wr_en   <= op_ok;    // One cycle pulse
                    bank.wr_en <= wr_due;
                    state      <= csr_pkg::STORE;
                end
                csr_pkg::STORE: begin
                    rd_wr_en   <= 1'b0;
                    bank.wr_en <= 1'b0;
                    ready      <= 1'b1;     // Next accept sees the new CSR
                    state      <= csr_pkg::IDLE;
                end
                default: state <= csr_pkg::IDLE;
            endcase
        end
    end

    // ----------------------------------------
    // Operand and result registers
    // ----------------------------------------

    always_ff @(posedge aclk) begin
        if (accept) begin
            funct3_r     <= funct3;
            rs1_idx_r    <= rs1_addr;
            zimm_r       <= zimm;
            rs1_val_r    <= rs1_val;
            rd_wr_addr   <= rd;
            bank.wr_addr <= csr_addr;
        end
        if (state == csr_pkg::COMPUTE) begin
            rd_wr_val    <= bank.rd_data;   // Old CSR value to rd
            bank.wr_data <= newval;
        end
    end

endmodule

`default_nettype wire

// ==== logic/csr_bank.sv ====
/* Machine CSR storage */

`timescale 1ns/1ps
`default_nettype none

`include "csr_params.svh"

module csr_bank (
    input  logic        aclk,
    input  logic        aresetn,
    input  logic        srst,
    csr_bank_if.bank    bank
);

    // ----------------------------------------
    // Registers
    // ----------------------------------------

    csr_pkg::xlen_t mstatus;        // 0x300
    csr_pkg::xlen_t misa;           // 0x301, read-only
    csr_pkg::xlen_t mtvec;          // 0x305
    csr_pkg::xlen_t mscratch;       // 0x340
    csr_pkg::xlen_t mepc;           // 0x341
    csr_pkg::xlen_t mcause;         // 0x342
    csr_pkg::xlen_t mtval;          // 0x343
    csr_pkg::xlen_t mhartid;        // 0xF14, read-only

    // ----------------------------------------
    // Constant registers
    // ----------------------------------------

    // MXL=1 on top, then I or E base bit
    always_comb begin
        misa = '0;
        misa[`CSR_XLEN-1 -: 2] = 2'b01;
        misa[8] = (`CSR_RV32E == 0);    // I
        misa[4] = (`CSR_RV32E != 0);    // E
    end

    assign mhartid = csr_pkg::xlen_t'(`CSR_MHART_ID);

    // ----------------------------------------
    // Write path
    // ----------------------------------------

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            mstatus  <= '0;
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
        end else if (srst) begin
            mstatus  <= '0;
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
        end else if (bank.wr_en) begin
            case (bank.wr_addr)
                `ADDR_MSTATUS:  mstatus  <= bank.wr_data & `MSTATUS_WMASK;
                `ADDR_MTVEC:    mtvec    <= bank.wr_data;
                `ADDR_MSCRATCH: mscratch <= bank.wr_data;
                `ADDR_MEPC:     mepc     <= {bank.wr_data[`CSR_XLEN-1:2], 2'b00}; // IALIGN=32
                `ADDR_MCAUSE:   mcause   <= bank.wr_data;
                `ADDR_MTVAL:    mtval    <= bank.wr_data;
                default: ;      // misa, mhartid and holes drop the write
            endcase
        end
    end

    // ----------------------------------------
    // Read path
    // ----------------------------------------

    // Sampled on the accept edge
    always_ff @(posedge aclk) begin
        if (bank.rd_en) begin
            case (bank.rd_addr)
                `ADDR_MSTATUS:  bank.rd_data <= mstatus;
                `ADDR_MISA:     bank.rd_data <= misa;
                `ADDR_MTVEC:    bank.rd_data <= mtvec;
                `ADDR_MSCRATCH: bank.rd_data <= mscratch;
                `ADDR_MEPC:     bank.rd_data <= mepc;
                `ADDR_MCAUSE:   bank.rd_data <= mcause;
                `ADDR_MTVAL:    bank.rd_data <= mtval;
                `ADDR_MHARTID:  bank.rd_data <= mhartid;
                default:        bank.rd_data <= '0;     // Unmapped
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/csr_bank_if.sv ====
/* CSR bank access port */

`timescale 1ns/1ps
`default_nettype none

interface csr_bank_if;

    // Read side, one cycle latency
    logic                rd_en;
    csr_pkg::csr_addr_t  rd_addr;
    csr_pkg::xlen_t      rd_data;     // Held until next read

    // Write side, lands at the edge
    logic                wr_en;
    csr_pkg::csr_addr_t  wr_addr;
    csr_pkg::xlen_t      wr_data;

    // Execution unit end
    modport exec (
        output rd_en, rd_addr,
        input  rd_data,
        output wr_en, wr_addr, wr_data
    );

    // Storage end
    modport bank (
        input  rd_en, rd_addr,
        output rd_data,
        input  wr_en, wr_addr, wr_data
    );

endinterface

`default_nettype wire

// ==== logic/csr_pkg.sv ====
/* CSR unit types */

`default_nettype none

`include "csr_params.svh"

package csr_pkg;

    // ----------------------------------------
    // Data widths
    // ----------------------------------------

    // One register or CSR value
    typedef logic [`CSR_XLEN-1:0] xlen_t;

    // Raw instruction word
    typedef logic [`INST_W-1:0] inst_t;

    // ----------------------------------------
    // Instruction fields
    // ----------------------------------------

    typedef logic [`RD_W-1:0] reg_addr_t;       // x0..x31 index
    typedef logic [`CSR_W-1:0] csr_addr_t;      // 4K CSR space
    typedef logic [`FUNCT3_W-1:0] funct3_t;     // Zicsr op

    // ----------------------------------------
    // Execution FSM
    // ----------------------------------------

    // IDLE waits for an instruction
    // COMPUTE forms the new value, STORE lets the writes land
    typedef enum logic [1:0] {
        IDLE,
        COMPUTE,
        STORE
    } exec_state_t;

endpackage

`default_nettype wire

// ==== include/csr_params.svh ====
/* CSR unit build parameters */

`ifndef CSR_PARAMS_SVH
`define CSR_PARAMS_SVH

// ----------------------------------------
// Build options
// ----------------------------------------
`define CSR_XLEN        32          // Register width
`define CSR_MHART_ID    0           // Value of mhartid
`define CSR_RV32E       0           // 1 selects the E base in misa

`define INST_W          32          // Instruction bus width

// ----------------------------------------
// Instruction fields (lsb and width)
// ----------------------------------------
`define OPCODE          0
`define OPCODE_W        7
`define RD              7
`define RD_W            5
`define FUNCT3          12
`define FUNCT3_W        3
`define RS1             15
`define RS1_W           5
`define ZIMM            15          // Shares bits with rs1
`define ZIMM_W          5
`define CSR             20
`define CSR_W           12

// Zicsr funct3 encodings
`define CSRRW           3'b001
`define CSRRS           3'b010
`define CSRRC           3'b011
`define CSRRWI          3'b101
`define CSRRSI          3'b110
`define CSRRCI          3'b111

// ----------------------------------------
// Machine CSR map
// ----------------------------------------
`define ADDR_MSTATUS    12'h300
`define ADDR_MISA       12'h301
`define ADDR_MTVEC      12'h305
`define ADDR_MSCRATCH   12'h340
`define ADDR_MEPC       12'h341
`define ADDR_MCAUSE     12'h342
`define ADDR_MTVAL      12'h343
`define ADDR_MHARTID    12'hF14

// Writable mstatus bits: 31, 22:11, 8:7, 5:3, 1:0
`define MSTATUS_WMASK   32'h807F_F9BB

`endif
